//--- common/ram_consts.svh
`ifndef RAM_CONSTS_SVH
`define RAM_CONSTS_SVH

// request and RAM address width
`define ADDR_W 32

// request word width
`define WORD_W 32

// RAM is one byte wide
`define BYTE_W 8

`endif

//--- common/memPkg.sv
`default_nettype none

package memPkg;

    // owner of the current grant
    typedef enum logic [1:0] {
        srcNone = 2'd0,
        srcInst = 2'd1,
        srcData = 2'd2
    } reqSrc;

    // arbiter states
    typedef enum logic [1:0] {
        stIdle = 2'd0,
        stRun  = 2'd1,
        stDone = 2'd2
    } ctrlState;

    // byte lane within a word, little-endian
    typedef logic [1:0] byteIdx;

    // transfer length, legal values are 1, 2 and 4
    typedef logic [2:0] byteCnt;

endpackage

`default_nettype wire

//--- common/laneCtrlIf.sv
`timescale 1ns/1ps
`default_nettype none

interface laneCtrlIf;
    import memPkg::*;

    logic   grant;
    reqSrc  grantSrc;
    logic   issue;
    byteIdx issueIdx;
    logic   write;
    logic   capture;
    byteIdx captureIdx;

    modport ctrl (
        output grant,
        output grantSrc,
        output issue,
        output issueIdx,
        output write,
        output capture,
        output captureIdx
    );

    // RAM request side
    modport port (
        input grant,
        input grantSrc,
        input issue,
        input issueIdx,
        input write
    );

    modport gather (
        input grant,
        input capture,
        input captureIdx
    );

endinterface

`default_nettype wire

//--- memCtrl/memArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
    input  logic          clk,
    input  logic          rst,
    input  logic          rdy,
    input  logic          ioBufferFull,
    input  logic          instEn,
    input  logic          dataEn,
    input  logic          dataWrite,
    input  memPkg::byteCnt dataLen,
    output logic          instDone,
    output logic          dataDone,
    laneCtrlIf.ctrl       lane
);
    import memPkg::*;

    logic     stall;
    ctrlState state;
    reqSrc    curSrc;
    reqSrc    nextSrc;
    byteCnt   xferLen;
    byteCnt   issCnt;
    byteCnt   capCnt;
    logic     isWrite;
    logic     capFlag;
    logic     lastIssue;
    logic     lastCapture;
    logic     xferEnd;

    // either input freezes the request side
    assign stall = ioBufferFull || !rdy;

    // data port has priority over fetch
    always_comb begin
        if (dataEn) begin
            nextSrc = srcData;
        end else if (instEn) begin
            nextSrc = srcInst;
        end else begin
            nextSrc = srcNone;
        end
    end

    assign lane.grant    = (state == stIdle) && !stall && (instEn || dataEn);
    assign lane.grantSrc = nextSrc;

    // one byte per unstalled cycle until the length is reached
    assign lane.issue    = (state == stRun) && !stall && (issCnt != xferLen);
    assign lane.issueIdx = byteIdx'(issCnt);
    assign lane.write    = isWrite;

    // ramDout holds the byte issued one cycle earlier
    assign lane.capture    = capFlag;
    assign lane.captureIdx = byteIdx'(capCnt);

    assign lastIssue   = lane.issue && (byteCnt'(issCnt + 3'd1) == xferLen);
    assign lastCapture = capFlag && (byteCnt'(capCnt + 3'd1) == xferLen);

    // stores finish on the last issue, loads on the last capture
    assign xferEnd = isWrite ? lastIssue : lastCapture;

    // done is high in the cycle that leaves stDone, so it is one cycle wide
    assign instDone = (state == stDone) && !stall && (curSrc == srcInst);
    assign dataDone = (state == stDone) && !stall && (curSrc == srcData);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= stIdle;
            curSrc  <= srcNone;
            xferLen <= '0;
            issCnt  <= '0;
            capCnt  <= '0;
            isWrite <= 1'b0;
            capFlag <= 1'b0;
        end else begin
            capFlag <= lane.issue && !isWrite;

            if (lane.issue) begin
                issCnt <= issCnt + 3'd1;
            end
            if (lane.capture) begin
                capCnt <= capCnt + 3'd1;
            end

            case (state)
                stIdle: begin
                    if (lane.grant) begin
                        state  <= stRun;
                        curSrc <= nextSrc;
                        issCnt <= '0;
                        capCnt <= '0;
                        if (dataEn) begin
                            xferLen <= dataLen;
                            isWrite <= dataWrite;
                        end else begin
                            // fetch is always a full word
                            xferLen <= 3'd4;
                            isWrite <= 1'b0;
                        end
                    end
                end
                stRun: begin
                    if (xferEnd) begin
                        state <= stDone;
                    end
                end
                stDone: begin
                    if (!stall) begin
                        state  <= stIdle;
                        curSrc <= srcNone;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- memCtrl/ramPortDriver.sv
`timescale 1ns/1ps
`default_nettype none

`include "ram_consts.svh"

module ramPortDriver (
    input  logic               clk,
    input  logic               rst,
    input  logic [`ADDR_W-1:0] instAddr,
    input  logic [`ADDR_W-1:0] dataAddr,
    input  logic [`WORD_W-1:0] dataWdata,
    laneCtrlIf.port            lane,
    output logic [`ADDR_W-1:0] ramAddr,
    output logic [`BYTE_W-1:0] ramDin,
    output logic               ramWe
);
    import memPkg::*;

    logic [`ADDR_W-1:0] baseAddr;
    logic [`WORD_W-1:0] storeWord;

    always_ff @(posedge clk) begin
        if (rst) begin
            baseAddr  <= '0;
            storeWord <= '0;
        end else if (lane.grant) begin
            if (lane.grantSrc == srcData) begin
                baseAddr  <= dataAddr;
                storeWord <= dataWdata;
            end else begin
                baseAddr  <= instAddr;
                storeWord <= '0;
            end
        end
    end

    // consecutive byte addresses, little-endian
    assign ramAddr = baseAddr + `ADDR_W'(lane.issueIdx);
    assign ramDin  = storeWord[lane.issueIdx * `BYTE_W +: `BYTE_W];
    assign ramWe   = lane.issue && lane.write;

endmodule

`default_nettype wire

//--- memCtrl/loadAssembler.sv
`timescale 1ns/1ps
`default_nettype none

`include "ram_consts.svh"

module loadAssembler (
    input  logic               clk,
    input  logic               rst,
    input  logic [`BYTE_W-1:0] ramDout,
    laneCtrlIf.gather          lane,
    output logic [`WORD_W-1:0] word
);

    always_ff @(posedge clk) begin
        if (rst) begin
            word <= '0;
        end else if (lane.grant) begin
            // upper lanes stay zero on short loads
            word <= '0;
        end else if (lane.capture) begin
            word[lane.captureIdx * `BYTE_W +: `BYTE_W] <= ramDout;
        end
    end

endmodule

`default_nettype wire

//--- hdl/memCtrlTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "ram_consts.svh"

module memCtrlTop (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               ioBufferFull,

    // instruction fetch
    input  logic               instEn,
    input  logic [`ADDR_W-1:0] instAddr,
    output logic               instDone,
    output logic [`WORD_W-1:0] instData,

    // data port
    input  logic               dataEn,
    input  logic               dataWrite,
    input  memPkg::byteCnt     dataLen,
    input  logic [`ADDR_W-1:0] dataAddr,
    input  logic [`WORD_W-1:0] dataWdata,
    output logic               dataDone,
    output logic [`WORD_W-1:0] dataRdata,

    // byte-wide RAM
    output logic [`ADDR_W-1:0] ramAddr,
    output logic [`BYTE_W-1:0] ramDin,
    output logic               ramWe,
    input  logic [`BYTE_W-1:0] ramDout
);

    logic [`WORD_W-1:0] loadWord;

    laneCtrlIf lane ();

    memArbiter arbiter (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .instEn       (instEn),
        .dataEn       (dataEn),
        .dataWrite    (dataWrite),
        .dataLen      (dataLen),
        .instDone     (instDone),
        .dataDone     (dataDone),
        .lane         (lane.ctrl)
    );

    ramPortDriver portDriver (
        .clk       (clk),
        .rst       (rst),
        .instAddr  (instAddr),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .lane      (lane.port),
        .ramAddr   (ramAddr),
        .ramDin    (ramDin),
        .ramWe     (ramWe)
    );

    loadAssembler assembler (
        .clk     (clk),
        .rst     (rst),
        .ramDout (ramDout),
        .lane    (lane.gather),
        .word    (loadWord)
    );

    // both requesters see the same result word, qualified by their done
    assign instData  = loadWord;
    assign dataRdata = loadWord;

endmodule

`default_nettype wire

//--- bench/ramModel.sv
`timescale 1ns/1ps
`default_nettype none

`include "ram_consts.svh"

module ramModel #(
    parameter int          DEPTH = 256,
    parameter logic [31:0] SEED  = 32'he3e
) (
    input  logic               clk,
    input  logic [`ADDR_W-1:0] addr,
    input  logic [`BYTE_W-1:0] din,
    input  logic               we,
    output logic [`BYTE_W-1:0] dout
);

    localparam int AW = $clog2(DEPTH);

    logic [`BYTE_W-1:0] mem [0:DEPTH-1];
    logic [AW-1:0]      idx;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // every byte also mixes in its own address
    initial begin : preload
        logic [31:0] s;
        s = SEED;
        for (int i = 0; i < DEPTH; i++) begin
            s = lcgNext(s);
            mem[i] = s[31:24] ^ 8'(i);
        end
    end

    assign idx = addr[AW-1:0];

    // read data shows up one cycle after the address
    always @(posedge clk) begin
        if (we) begin
            mem[idx] <= din;
        end
        dout <= mem[idx];
    end

endmodule

`default_nettype wire

//--- bench/memCtrlTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ram_consts.svh"

module memCtrlTb;

    localparam int RESET_CYCLES   = 10;
    localparam int RAND_INST      = 20;
    localparam int RAND_DATA      = 40;
    // idle check, fetches, loads, store and reload pairs, dual requests, mixed traffic
    localparam int NUM_TXN        = 1 + 4 + 3 + 6 + 4 + RAND_INST + RAND_DATA;
    localparam int CYCLES_PER_TXN = 20;

    logic               clk;
    logic               rst;
    logic               rdy;
    logic               ioBufferFull;
    logic               instEn;
    logic [`ADDR_W-1:0] instAddr;
    logic               instDone;
    logic [`WORD_W-1:0] instData;
    logic               dataEn;
    logic               dataWrite;
    memPkg::byteCnt     dataLen;
    logic [`ADDR_W-1:0] dataAddr;
    logic [`WORD_W-1:0] dataWdata;
    logic               dataDone;
    logic [`WORD_W-1:0] dataRdata;
    logic [`ADDR_W-1:0] ramAddr;
    logic [`BYTE_W-1:0] ramDin;
    logic               ramWe;
    logic [`BYTE_W-1:0] ramDout;

    logic [`BYTE_W-1:0] refMem [0:255];
    logic [31:0]        rngData;
    logic [31:0]        rngInst;
    logic [31:0]        rngStall;
    logic               trafficDone;

    memCtrlTop DUT (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .instEn       (instEn),
        .instAddr     (instAddr),
        .instDone     (instDone),
        .instData     (instData),
        .dataEn       (dataEn),
        .dataWrite    (dataWrite),
        .dataLen      (dataLen),
        .dataAddr     (dataAddr),
        .dataWdata    (dataWdata),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .ramAddr      (ramAddr),
        .ramDin       (ramDin),
        .ramWe        (ramWe),
        .ramDout      (ramDout)
    );

    ramModel ram (
        .clk  (clk),
        .addr (ramAddr),
        .din  (ramDin),
        .we   (ramWe),
        .dout (ramDout)
    );

    initial begin : clockGen
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // little-endian, zero-extended
    function automatic logic [31:0] refWord(input logic [31:0] addr, input logic [2:0] len);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < int'(len); i++) begin
            w[i*8 +: 8] = refMem[addr[7:0] + 8'(i)];
        end
        return w;
    endfunction

    function automatic logic [2:0] pickLen(input logic [31:0] r);
        case (r[25:24])
            2'd0: return 3'd1;
            2'd1: return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    // fetches stay in the low half, data traffic in the high half
    function automatic logic [31:0] pickFetchAddr(input logic [31:0] r);
        return (r >> 8) % 32'd125;
    endfunction

    function automatic logic [31:0] pickDataAddr(input logic [31:0] r);
        return 32'd128 + (r >> 8) % 32'd124;
    endfunction

    task automatic abortRun();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string testName, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("** Error: %s expected %h actual %h", testName, expected, actual);
        abortRun();
    endtask

    task automatic applyStore(input logic [31:0] addr, input logic [2:0] len,
                              input logic [31:0] wdata);
        for (int i = 0; i < int'(len); i++) begin
            refMem[addr[7:0] + 8'(i)] = wdata[i*8 +: 8];
        end
    endtask

    task automatic compareRam(input int lo, input int hi);
        for (int a = lo; a <= hi; a++) begin
            assert (ram.mem[a[7:0]] == refMem[a[7:0]])
                else reportMismatch($sformatf("ram byte %0d", a),
                                    32'(refMem[a[7:0]]), 32'(ram.mem[a[7:0]]));
        end
    endtask

    task automatic fetchWord(input string testName, input logic [31:0] addr,
                             input logic checkTiming, output time doneAt);
        logic [31:0] expWord;
        int          cyc;
        expWord = refWord(addr, 3'd4);
        @(posedge clk);
        #1;
        instEn   = 1'b1;
        instAddr = addr;
        cyc = 0;
        @(negedge clk);
        while (!instDone) begin
            @(negedge clk);
            cyc++;
        end
        doneAt = $time;
        assert (instData == expWord) else reportMismatch(testName, expWord, instData);
        if (checkTiming) begin
            assert (cyc == 6)
                else reportMismatch({testName, " done cycle"}, 32'd6, 32'(cyc));
        end
        @(posedge clk);
        #1;
        instEn = 1'b0;
    endtask

    task automatic dataAccess(input string testName, input logic wr, input logic [2:0] len,
                              input logic [31:0] addr, input logic [31:0] wdata,
                              input logic checkTiming, output time doneAt);
        logic [31:0] expWord;
        int          expCyc;
        int          cyc;
        expWord = refWord(addr, len);
        expCyc  = wr ? int'(len) + 1 : int'(len) + 2;
        @(posedge clk);
        #1;
        dataEn    = 1'b1;
        dataWrite = wr;
        dataLen   = len;
        dataAddr  = addr;
        dataWdata = wdata;
        cyc = 0;
        @(negedge clk);
        while (!dataDone) begin
            @(negedge clk);
            cyc++;
        end
        doneAt = $time;
        if (!wr) begin
            assert (dataRdata == expWord) else reportMismatch(testName, expWord, dataRdata);
        end else begin
            applyStore(addr, len, wdata);
        end
        if (checkTiming) begin
            assert (cyc == expCyc)
                else reportMismatch({testName, " done cycle"}, 32'(expCyc), 32'(cyc));
        end
        @(posedge clk);
        #1;
        dataEn = 1'b0;
    endtask

    task automatic driveStalls();
        while (!trafficDone) begin
            @(posedge clk);
            #1;
            rngStall     = lcgNext(rngStall);
            ioBufferFull = (rngStall[28:26] == 3'd0);
            rdy          = (rngStall[20:18] != 3'd0);
        end
        ioBufferFull = 1'b0;
        rdy          = 1'b1;
    endtask

    task automatic fetchTraffic();
        time doneAt;
        for (int k = 0; k < RAND_INST; k++) begin
            rngInst = lcgNext(rngInst);
            repeat (int'(rngInst[27:26])) @(posedge clk);
            fetchWord($sformatf("mixed fetch %0d", k), pickFetchAddr(rngInst), 1'b0, doneAt);
        end
    endtask

    task automatic dataTraffic();
        logic [31:0] addr;
        logic [2:0]  len;
        logic        wr;
        time         doneAt;
        for (int k = 0; k < RAND_DATA; k++) begin
            rngData = lcgNext(rngData);
            wr      = rngData[30];
            len     = pickLen(rngData);
            addr    = pickDataAddr(rngData);
            rngData = lcgNext(rngData);
            dataAccess($sformatf("mixed data %0d write %0b", k, wr), wr, len, addr, rngData,
                       1'b0, doneAt);
            rngData = lcgNext(rngData);
            repeat (1 + int'(rngData[27:26])) @(posedge clk);
        end
    endtask

    // no store may slip through a stall
    assert property (@(posedge clk) disable iff (rst) !(ramWe && (ioBufferFull || !rdy)))
        else begin
            $display("** Error: ramWe was high while a stall input was high");
            abortRun();
        end

    assert property (@(posedge clk) disable iff (rst) !(instDone && dataDone))
        else begin
            $display("** Error: instDone and dataDone were high together");
            abortRun();
        end

    assert property (@(posedge clk) disable iff (rst) instDone |=> !instDone)
        else begin
            $display("** Error: instDone stayed high for more than one cycle");
            abortRun();
        end

    assert property (@(posedge clk) disable iff (rst) dataDone |=> !dataDone)
        else begin
            $display("** Error: dataDone stayed high for more than one cycle");
            abortRun();
        end

    initial begin : watchdog
        repeat (RESET_CYCLES + NUM_TXN * CYCLES_PER_TXN) @(posedge clk);
        $display("** Error: timeout after %0d cycles, a request never completed",
                 RESET_CYCLES + NUM_TXN * CYCLES_PER_TXN);
        abortRun();
    end

    initial begin : mainSeq
        time         instAt;
        time         dataAt;
        logic [31:0] addr;
        logic [2:0]  len;
        logic [31:0] fillState;
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        instEn       = 1'b0;
        instAddr     = '0;
        dataEn       = 1'b0;
        dataWrite    = 1'b0;
        dataLen      = 3'd0;
        dataAddr     = '0;
        dataWdata    = '0;
        trafficDone  = 1'b0;
        rngData      = 32'he3e;
        rngInst      = 32'he3e ^ 32'h5555_0000;
        rngStall     = 32'he3e ^ 32'haaaa_0000;

        // same fill rule as the RAM model
        fillState = 32'he3e;
        for (int i = 0; i < 256; i++) begin
            fillState = lcgNext(fillState);
            refMem[i] = fillState[31:24] ^ 8'(i);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (20) begin
            @(negedge clk);
            assert (!instDone && !dataDone && !ramWe)
                else begin
                    $display("** Error: done or ramWe active without any request");
                    abortRun();
                end
        end

        for (int k = 0; k < 4; k++) begin
            rngInst = lcgNext(rngInst);
            fetchWord($sformatf("fetch %0d", k), pickFetchAddr(rngInst), 1'b1, instAt);
        end

        for (int k = 0; k < 3; k++) begin
            len     = 3'd1 << k;
            rngData = lcgNext(rngData);
            dataAccess($sformatf("load len %0d", len), 1'b0, len, pickDataAddr(rngData), '0,
                       1'b1, dataAt);
        end

        for (int k = 0; k < 3; k++) begin
            len     = 3'd1 << k;
            rngData = lcgNext(rngData);
            addr    = pickDataAddr(rngData);
            rngData = lcgNext(rngData);
            dataAccess($sformatf("store len %0d", len), 1'b1, len, addr, rngData, 1'b1, dataAt);
            // neighbours of the store must be untouched
            compareRam(int'(addr) - 1, int'(addr) + 4);
            dataAccess($sformatf("reload len %0d", len), 1'b0, 3'd4, addr, '0, 1'b1, dataAt);
        end

        for (int k = 0; k < 2; k++) begin
            rngInst = lcgNext(rngInst);
            rngData = lcgNext(rngData);
            fork
                fetchWord($sformatf("dual fetch %0d", k), pickFetchAddr(rngInst), 1'b0, instAt);
                dataAccess($sformatf("dual load %0d", k), 1'b0, 3'd4, pickDataAddr(rngData), '0,
                           1'b0, dataAt);
            join
            assert (dataAt < instAt)
                else begin
                    $display("** Error: dual %0d, dataDone did not come before instDone", k);
                    abortRun();
                end
        end

        fork
            driveStalls();
            begin
                fork
                    fetchTraffic();
                    dataTraffic();
                join
                trafficDone = 1'b1;
            end
        join

        compareRam(0, 255);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+common
common/memPkg.sv
common/laneCtrlIf.sv
memCtrl/memArbiter.sv
memCtrl/ramPortDriver.sv
memCtrl/loadAssembler.sv
hdl/memCtrlTop.sv
bench/ramModel.sv
bench/memCtrlTb.sv

//--- Makefile
TOP := memCtrlTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir
